// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = mmioTb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Output is shown in full and scanned for the pass line.
run: compile
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

// ==== aclint.sv ====
module aclint import mmioPkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              re,
    input  logic [ADDR_W-1:0] raddr,
    output logic [DATA_W-1:0] rdata,
    output logic              rvalid,
    output logic              busy,

    input  logic              we,
    input  logic [MASK_W-1:0] wmask,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,

    output logic              timerIrq
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [63:0] mtimeNext;
    logic [63:0] mtimecmpNext;
    logic        hit;

    // Replace the bytes selected by mask.
    function automatic logic [DATA_W-1:0] mergeBytes(
        input logic [DATA_W-1:0] oldWord,
        input logic [DATA_W-1:0] newWord,
        input logic [MASK_W-1:0] mask
    );
        logic [DATA_W-1:0] result;
        result = oldWord;
        for (int i = 0; i < MASK_W; i++) begin
            if (mask[i]) begin
                result[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return result;
    endfunction

    // Timer never stalls the bus.
    assign busy = 1'b0;

    always_comb begin
        mtimeNext    = mtime + 64'd1;
        mtimecmpNext = mtimecmp;
        if (we) begin
            case (waddr)
                MTIME_LO:    mtimeNext[31:0]     = mergeBytes(mtime[31:0], wdata, wmask);
                MTIME_HI:    mtimeNext[63:32]    = mergeBytes(mtime[63:32], wdata, wmask);
                MTIMECMP_LO: mtimecmpNext[31:0]  = mergeBytes(mtimecmp[31:0], wdata, wmask);
                MTIMECMP_HI: mtimecmpNext[63:32] = mergeBytes(mtimecmp[63:32], wdata, wmask);
                default: ;
            endcase
        end
    end

    assign hit = re && (raddr == MTIME_LO || raddr == MTIME_HI ||
                        raddr == MTIMECMP_LO || raddr == MTIMECMP_HI);

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '1;
            timerIrq <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            mtime    <= mtimeNext;
            mtimecmp <= mtimecmpNext;
            timerIrq <= (mtime >= mtimecmp);
            rvalid   <= hit;
        end
    end

    // Read data, qualified by rvalid.
    always_ff @(posedge clk) begin
        case (raddr)
            MTIME_LO:    rdata <= mtime[31:0];
            MTIME_HI:    rdata <= mtime[63:32];
            MTIMECMP_LO: rdata <= mtimecmp[31:0];
            default:     rdata <= mtimecmp[63:32];
        endcase
    end

endmodule

// ==== mmio.sv ====
module mmio import mmioPkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              memRe,
    input  logic              memWe,
    input  logic [MASK_W-1:0] memWmask,
    input  logic [ADDR_W-1:0] memRaddr,
    input  logic [ADDR_W-1:0] memWaddr,
    input  logic [DATA_W-1:0] memWdata,
    output logic [DATA_W-1:0] memRdata,
    output logic              memRbusy,
    output logic              memWbusy,

    output logic              spiCs,
    output logic              spiSclk,
    output logic              spiMosi,
    input  logic              spiMiso,

    output logic              timerIrq
);

    logic              re;
    logic              we;
    logic [MASK_W-1:0] wmask;
    logic [ADDR_W-1:0] raddr;
    logic [ADDR_W-1:0] waddr;
    logic [DATA_W-1:0] wdata;

    logic [DATA_W-1:0] aclintRdata;
    logic              aclintRvalid;
    logic              aclintBusy;
    logic [DATA_W-1:0] spiRdata;
    logic              spiRvalid;
    logic              spiBusy;

    mmioBridge i_bridge (
        .clk          (clk),
        .rst          (rst),
        .memRe        (memRe),
        .memWe        (memWe),
        .memWmask     (memWmask),
        .memRaddr     (memRaddr),
        .memWaddr     (memWaddr),
        .memWdata     (memWdata),
        .memRdata     (memRdata),
        .memRbusy     (memRbusy),
        .memWbusy     (memWbusy),
        .aclintRdata  (aclintRdata),
        .aclintRvalid (aclintRvalid),
        .aclintBusy   (aclintBusy),
        .spiRdata     (spiRdata),
        .spiRvalid    (spiRvalid),
        .spiBusy      (spiBusy),
        .re           (re),
        .we           (we),
        .wmask        (wmask),
        .raddr        (raddr),
        .waddr        (waddr),
        .wdata        (wdata)
    );

    // ********************************************************************
    // Peripherals
    // ********************************************************************

    aclint i_aclint (
        .clk      (clk),
        .rst      (rst),
        .re       (re),
        .raddr    (raddr),
        .rdata    (aclintRdata),
        .rvalid   (aclintRvalid),
        .busy     (aclintBusy),
        .we       (we),
        .wmask    (wmask),
        .waddr    (waddr),
        .wdata    (wdata),
        .timerIrq (timerIrq)
    );

    spiMaster i_spi (
        .clk     (clk),
        .rst     (rst),
        .re      (re),
        .raddr   (raddr),
        .rdata   (spiRdata),
        .rvalid  (spiRvalid),
        .busy    (spiBusy),
        .we      (we),
        .wmask   (wmask),
        .waddr   (waddr),
        .wdata   (wdata),
        .spiCs   (spiCs),
        .spiSclk (spiSclk),
        .spiMosi (spiMosi),
        .spiMiso (spiMiso)
    );

endmodule

// ==== mmioBridge.sv ====
module mmioBridge import mmioPkg::*; (
    input  logic              clk,
    input  logic              rst,

    // Core side, active-low strobes.
    input  logic              memRe,
    input  logic              memWe,
    input  logic [MASK_W-1:0] memWmask,
    input  logic [ADDR_W-1:0] memRaddr,
    input  logic [ADDR_W-1:0] memWaddr,
    input  logic [DATA_W-1:0] memWdata,
    output logic [DATA_W-1:0] memRdata,
    output logic              memRbusy,
    output logic              memWbusy,

    // Peripheral responses.
    input  logic [DATA_W-1:0] aclintRdata,
    input  logic              aclintRvalid,
    input  logic              aclintBusy,
    input  logic [DATA_W-1:0] spiRdata,
    input  logic              spiRvalid,
    input  logic              spiBusy,

    // Broadcast request.
    output logic              re,
    output logic              we,
    output logic [MASK_W-1:0] wmask,
    output logic [ADDR_W-1:0] raddr,
    output logic [ADDR_W-1:0] waddr,
    output logic [DATA_W-1:0] wdata
);

    // ********************************************************************
    // Request stage
    // ********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            re <= 1'b0;
            we <= 1'b0;
        end else begin
            re <= !memRe;
            we <= !memWe && !memWbusy; // Only accepted writes.
        end
    end

    always_ff @(posedge clk) begin
        wmask <= memWmask;
        raddr <= memRaddr;
        waddr <= memWaddr;
        wdata <= memWdata;
    end

    // ********************************************************************
    // Response combining
    // ********************************************************************

    assign memRbusy = 1'b0;
    assign memWbusy = we || aclintBusy || spiBusy;

    always_comb begin
        memRdata = '0; // Unmapped reads return zero.
        if (aclintRvalid) begin
            memRdata = aclintRdata;
        end
        if (spiRvalid) begin
            memRdata = spiRdata;
        end
    end

endmodule

// ==== mmioPkg.sv ====
package mmioPkg;

    // ********************************************************************
    // Bus widths
    // ********************************************************************

    localparam int ADDR_W = 30;           // Word address.
    localparam int DATA_W = 32;
    localparam int MASK_W = DATA_W / 8;   // One bit per byte lane.

    // ********************************************************************
    // Address map, word addresses
    // ********************************************************************

    localparam logic [ADDR_W-1:0] ACLINT_BASE = 30'h0010_0000;

    localparam logic [ADDR_W-1:0] MTIME_LO    = ACLINT_BASE + 30'd0;
    localparam logic [ADDR_W-1:0] MTIME_HI    = ACLINT_BASE + 30'd1;
    localparam logic [ADDR_W-1:0] MTIMECMP_LO = ACLINT_BASE + 30'd2;
    localparam logic [ADDR_W-1:0] MTIMECMP_HI = ACLINT_BASE + 30'd3;

    localparam logic [ADDR_W-1:0] SPI_BASE = 30'h0010_0100;

    // Write starts a transfer, read gives {busy, rxByte}.
    localparam logic [ADDR_W-1:0] SPI_DATA = SPI_BASE + 30'd0;
    // Bit 0 is chip select, active low.
    localparam logic [ADDR_W-1:0] SPI_CTRL = SPI_BASE + 30'd1;

    // ********************************************************************
    // SPI timing
    // ********************************************************************

    localparam int SPI_HALF_PERIOD = 2;   // System clocks per SCLK half.
    localparam int SPI_HALF_W      = $clog2(SPI_HALF_PERIOD + 1);
    localparam int SPI_BITS        = 8;
    localparam int SPI_BIT_W       = $clog2(SPI_BITS);

endpackage

// ==== mmioTb.sv ====
module mmioTb import mmioPkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_TESTS = 64;

    localparam int OP_WRITE = 0;
    localparam int OP_READ = 1;
    localparam int OP_READ_INC = 2;  // Read must exceed the previous read.
    localparam int OP_WAIT = 3;      // Until memWbusy falls.
    localparam int OP_CS = 4;
    localparam int OP_IRQ = 5;

    logic              clk = 1'b0;
    logic              rst;
    logic              memRe;
    logic              memWe;
    logic [MASK_W-1:0] memWmask;
    logic [ADDR_W-1:0] memRaddr;
    logic [ADDR_W-1:0] memWaddr;
    logic [DATA_W-1:0] memWdata;
    logic [DATA_W-1:0] memRdata;
    logic              memRbusy;
    logic              memWbusy;
    logic              spiCs;
    logic              spiSclk;
    logic              spiMosi;
    logic              spiMiso;
    logic              timerIrq;

    string             names [MAX_TESTS];
    int                ops   [MAX_TESTS];
    logic [ADDR_W-1:0] addrs [MAX_TESTS];
    logic [DATA_W-1:0] datas [MAX_TESTS];
    logic [MASK_W-1:0] masks [MAX_TESTS];
    logic [DATA_W-1:0] exps  [MAX_TESTS];
    logic [DATA_W-1:0] cmps  [MAX_TESTS];
    int                numTests = 0;
    logic [DATA_W-1:0] lastRead = '0;
    int                sclkRises = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign spiMiso = spiMosi; // Loopback.

    always @(posedge spiSclk) begin
        sclkRises++;
    end

    mmio i_dut (
        .clk      (clk),
        .rst      (rst),
        .memRe    (memRe),
        .memWe    (memWe),
        .memWmask (memWmask),
        .memRaddr (memRaddr),
        .memWaddr (memWaddr),
        .memWdata (memWdata),
        .memRdata (memRdata),
        .memRbusy (memRbusy),
        .memWbusy (memWbusy),
        .spiCs    (spiCs),
        .spiSclk  (spiSclk),
        .spiMosi  (spiMosi),
        .spiMiso  (spiMiso),
        .timerIrq (timerIrq)
    );

    // ********************************************************************
    // Table building
    // ********************************************************************

    task automatic addEntry(input string name, input int op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [MASK_W-1:0] mask,
                            input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] cmp);
        names[numTests] = name;
        ops[numTests]   = op;
        addrs[numTests] = addr;
        datas[numTests] = data;
        masks[numTests] = mask;
        exps[numTests]  = exp;
        cmps[numTests]  = cmp;
        numTests++;
    endtask

    // Byte-lane model of a masked register write.
    function automatic logic [DATA_W-1:0] laneMerge(input logic [DATA_W-1:0] oldWord,
                                                    input logic [DATA_W-1:0] newWord,
                                                    input logic [MASK_W-1:0] mask);
        logic [DATA_W-1:0] laneBits;
        laneBits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (oldWord & ~laneBits) | (newWord & laneBits);
    endfunction

    task automatic buildTable();
        logic [63:0]       cmpModel;
        logic [DATA_W-1:0] r;
        logic [7:0]        b;
        cmpModel = '1;
        addEntry("cs_reset", OP_CS, '0, 32'h0, 4'b0, 32'h1, 32'h1);
        addEntry("irq_reset", OP_IRQ, '0, 32'h0, 4'b0, 32'h0, 32'h1);
        addEntry("cmp_lo_reset", OP_READ, MTIMECMP_LO, 32'h0, 4'b0, '1, '1);
        addEntry("cmp_hi_reset", OP_READ, MTIMECMP_HI, 32'h0, 4'b0, '1, '1);

        r = $urandom;
        addEntry("cmp_lo_wr5", OP_WRITE, MTIMECMP_LO, r, 4'b0101, 32'h0, 32'h0);
        cmpModel[31:0] = laneMerge(cmpModel[31:0], r, 4'b0101);
        addEntry("cmp_lo_rd5", OP_READ, MTIMECMP_LO, 32'h0, 4'b0, cmpModel[31:0], '1);
        r = $urandom;
        addEntry("cmp_hi_wr8", OP_WRITE, MTIMECMP_HI, r, 4'b1000, 32'h0, 32'h0);
        cmpModel[63:32] = laneMerge(cmpModel[63:32], r, 4'b1000);
        addEntry("cmp_hi_rd8", OP_READ, MTIMECMP_HI, 32'h0, 4'b0, cmpModel[63:32], '1);
        r = $urandom;
        addEntry("cmp_lo_wr2", OP_WRITE, MTIMECMP_LO, r, 4'b0010, 32'h0, 32'h0);
        cmpModel[31:0] = laneMerge(cmpModel[31:0], r, 4'b0010);
        addEntry("cmp_lo_rd2", OP_READ, MTIMECMP_LO, 32'h0, 4'b0, cmpModel[31:0], '1);
        r = $urandom;
        addEntry("cmp_hi_wr3", OP_WRITE, MTIMECMP_HI, r, 4'b0011, 32'h0, 32'h0);
        cmpModel[63:32] = laneMerge(cmpModel[63:32], r, 4'b0011);
        addEntry("cmp_hi_rd3", OP_READ, MTIMECMP_HI, 32'h0, 4'b0, cmpModel[63:32], '1);

        addEntry("mtime_first", OP_READ_INC, MTIME_LO, 32'h0, 4'b0, 32'h0, 32'h0);
        addEntry("mtime_second", OP_READ_INC, MTIME_LO, 32'h0, 4'b0, 32'h0, 32'h0);
        addEntry("mtime_hi", OP_READ, MTIME_HI, 32'h0, 4'b0, 32'h0, '1);

        // Compare value below the current mtime.
        addEntry("cmp_hi_zero", OP_WRITE, MTIMECMP_HI, 32'h0, 4'b1111, 32'h0, 32'h0);
        addEntry("cmp_lo_small", OP_WRITE, MTIMECMP_LO, 32'h4, 4'b1111, 32'h0, 32'h0);
        addEntry("irq_set", OP_IRQ, '0, 32'h0, 4'b0, 32'h1, 32'h1);
        addEntry("cmp_lo_back", OP_READ, MTIMECMP_LO, 32'h0, 4'b0, 32'h4, '1);

        for (int n = 0; n < 4; n++) begin
            b = 8'($urandom);
            addEntry($sformatf("spi_send%0d", n), OP_WRITE, SPI_DATA, {24'h0, b}, 4'b0001,
                     32'h0, 32'h0);
            addEntry($sformatf("spi_busy%0d", n), OP_READ, SPI_DATA, 32'h0, 4'b0,
                     32'h100, 32'h100);
            addEntry($sformatf("spi_wait%0d", n), OP_WAIT, '0, 32'h0, 4'b0,
                     32'(SPI_BITS * (n + 1)), '1);
            addEntry($sformatf("spi_echo%0d", n), OP_READ, SPI_DATA, 32'h0, 4'b0,
                     {24'h0, b}, 32'h1ff);
        end

        addEntry("cs_low_wr", OP_WRITE, SPI_CTRL, 32'h0, 4'b0001, 32'h0, 32'h0);
        addEntry("cs_low", OP_CS, '0, 32'h0, 4'b0, 32'h0, 32'h1);
        addEntry("cs_low_rd", OP_READ, SPI_CTRL, 32'h0, 4'b0, 32'h0, 32'h1);
        addEntry("cs_high_wr", OP_WRITE, SPI_CTRL, 32'h1, 4'b0001, 32'h0, 32'h0);
        addEntry("cs_high", OP_CS, '0, 32'h0, 4'b0, 32'h1, 32'h1);
        addEntry("cs_high_rd", OP_READ, SPI_CTRL, 32'h0, 4'b0, 32'h1, 32'h1);

        addEntry("unmapped_low", OP_READ, 30'h0000_1234, 32'h0, 4'b0, 32'h0, '1);
        addEntry("unmapped_gap", OP_READ, ACLINT_BASE + 30'd4, 32'h0, 4'b0, 32'h0, '1);
    endtask

    // ********************************************************************
    // Bus driver
    // ********************************************************************

    task automatic busRead(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] value);
        @(posedge clk);
        memRe    <= 1'b0;
        memRaddr <= addr;
        @(posedge clk);
        memRe <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        value = memRdata; // Valid after the second edge.
    endtask

    task automatic busWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [MASK_W-1:0] mask, output logic busyAfter);
        @(negedge clk);
        while (memWbusy) begin
            @(negedge clk);
        end
        @(posedge clk);
        memWe    <= 1'b0;
        memWaddr <= addr;
        memWdata <= data;
        memWmask <= mask;
        @(posedge clk);
        memWe <= 1'b1; // Taken at this edge.
        @(negedge clk);
        busyAfter = memWbusy;
    endtask

    function automatic void showMismatch(input string name, input logic [DATA_W-1:0] exp,
                                         input logic [DATA_W-1:0] act);
        $display("error %s: expected %h, actual %h", name, exp, act);
    endfunction

    task automatic runEntry(input int i, output logic ok);
        logic [DATA_W-1:0] value;
        logic              busyAfter;
        logic              seen;
        ok = 1'b1;
        case (ops[i])
            OP_WRITE: begin
                busWrite(addrs[i], datas[i], masks[i], busyAfter);
                if (busyAfter !== 1'b1) begin
                    $display("error %s: memWbusy expected 1, actual %b", names[i], busyAfter);
                    ok = 1'b0;
                end
            end
            OP_READ: begin
                busRead(addrs[i], value);
                if ((value & cmps[i]) !== (exps[i] & cmps[i])) begin
                    showMismatch(names[i], exps[i] & cmps[i], value & cmps[i]);
                    ok = 1'b0;
                end
                if (memRbusy !== 1'b0) begin
                    $display("error %s: memRbusy expected 0, actual %b", names[i], memRbusy);
                    ok = 1'b0;
                end
            end
            OP_READ_INC: begin
                busRead(addrs[i], value);
                if ((value > lastRead) !== 1'b1) begin
                    $display("error %s: expected above %h, actual %h", names[i], lastRead, value);
                    ok = 1'b0;
                end
                lastRead = value;
            end
            OP_WAIT: begin
                @(negedge clk);
                while (memWbusy) begin
                    @(negedge clk);
                end
                if (32'(sclkRises) !== exps[i]) begin
                    showMismatch(names[i], exps[i], 32'(sclkRises));
                    ok = 1'b0;
                end
                if (spiSclk !== 1'b0) begin
                    $display("error %s: spiSclk expected 0, actual %b", names[i], spiSclk);
                    ok = 1'b0;
                end
            end
            OP_CS: begin
                @(posedge clk);
                @(negedge clk);
                if (spiCs !== exps[i][0]) begin
                    showMismatch(names[i], exps[i], {31'h0, spiCs});
                    ok = 1'b0;
                end
            end
            default: begin
                seen = 1'b0;
                if (exps[i][0]) begin
                    for (int k = 0; k < 8 && !seen; k++) begin
                        @(negedge clk);
                        seen = (timerIrq === 1'b1);
                    end
                    if (!seen) begin
                        showMismatch(names[i], 32'h1, 32'h0);
                        ok = 1'b0;
                    end
                    for (int k = 0; k < 8 && ok; k++) begin
                        @(negedge clk);
                        if (timerIrq !== 1'b1) begin
                            $display("error %s: timerIrq dropped after it was raised", names[i]);
                            ok = 1'b0;
                        end
                    end
                end else begin
                    @(negedge clk);
                    if (timerIrq !== 1'b0) begin
                        showMismatch(names[i], 32'h0, {31'h0, timerIrq});
                        ok = 1'b0;
                    end
                end
            end
        endcase
    endtask

    // ********************************************************************
    // Main sequence and watchdog
    // ********************************************************************

    initial begin
        int          passCount;
        int          failCount;
        logic        ok;
        passCount = 0;
        failCount = 0;
        rst      = 1'b1;
        memRe    = 1'b1;
        memWe    = 1'b1;
        memWmask = '0;
        memRaddr = '0;
        memWaddr = '0;
        memWdata = '0;
        void'($urandom(1));
        buildTable();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < numTests; i++) begin
            runEntry(i, ok);
            if (ok) begin
                passCount++;
            end else begin
                failCount++;
            end
            $display("%-14s %s", names[i], ok ? "ok" : "FAILED");
        end
        $display("%0d tests, %0d passed, %0d failed", numTests, passCount, failCount);
        if (failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #1;
        #((numTests * 64 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the test table did not finish in time");
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== spiMaster.sv ====
module spiMaster import mmioPkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              re,
    input  logic [ADDR_W-1:0] raddr,
    output logic [DATA_W-1:0] rdata,
    output logic              rvalid,
    output logic              busy,

    input  logic              we,
    input  logic [MASK_W-1:0] wmask,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,

    output logic              spiCs,
    output logic              spiSclk,
    output logic              spiMosi,
    input  logic              spiMiso
);

    logic [SPI_BITS-1:0]   shiftReg;
    logic [SPI_BITS-1:0]   rxByte;
    logic [SPI_BIT_W-1:0]  bitCnt;
    logic [SPI_HALF_W-1:0] halfCnt;
    logic                  start;
    logic                  ctrlWrite;
    logic                  halfDone;
    logic                  hit;

    assign start     = we && waddr == SPI_DATA && wmask[0] && !busy;
    assign ctrlWrite = we && waddr == SPI_CTRL && wmask[0];
    assign halfDone  = halfCnt == SPI_HALF_W'(SPI_HALF_PERIOD - 1);
    assign hit       = re && (raddr == SPI_DATA || raddr == SPI_CTRL);

    // ********************************************************************
    // Shift engine, mode 0, MSB first
    // ********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            spiSclk <= 1'b0;
            spiMosi <= 1'b0;
            bitCnt  <= '0;
            halfCnt <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            spiMosi <= wdata[SPI_BITS-1]; // First bit ahead of the rising edge.
            bitCnt  <= '0;
            halfCnt <= '0;
        end else if (busy) begin
            if (halfDone) begin
                halfCnt <= '0;
                spiSclk <= !spiSclk;
                if (spiSclk) begin
                    // Falling edge.
                    if (bitCnt == SPI_BIT_W'(SPI_BITS - 1)) begin
                        busy    <= 1'b0;
                        spiMosi <= 1'b0;
                    end else begin
                        bitCnt  <= bitCnt + 1'b1;
                        spiMosi <= shiftReg[SPI_BITS-1];
                    end
                end
            end else begin
                halfCnt <= halfCnt + 1'b1;
            end
        end
    end

    // Shift and receive registers.
    always_ff @(posedge clk) begin
        if (start) begin
            shiftReg <= wdata[SPI_BITS-1:0];
        end else if (busy && halfDone) begin
            if (!spiSclk) begin
                shiftReg <= {shiftReg[SPI_BITS-2:0], spiMiso}; // Rising edge.
            end else if (bitCnt == SPI_BIT_W'(SPI_BITS - 1)) begin
                rxByte <= shiftReg;
            end
        end
    end

    // ********************************************************************
    // Chip select and register reads
    // ********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            spiCs  <= 1'b1;
            rvalid <= 1'b0;
        end else begin
            if (ctrlWrite) begin
                spiCs <= wdata[0];
            end
            rvalid <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (raddr == SPI_CTRL) begin
            rdata <= {{(DATA_W-1){1'b0}}, spiCs};
        end else begin
            rdata <= {{(DATA_W-SPI_BITS-1){1'b0}}, busy, rxByte};
        end
    end

endmodule

// ==== verilog.f ====
mmioPkg.sv
aclint.sv
spiMaster.sv
mmioBridge.sv
mmio.sv
mmioTb.sv
